//--- build.f
common/mips_pkg.sv
core/regfile.sv
core/mips_core.sv
verilog/mem_req_fifo.sv
verilog/wishbone_bus.sv
verilog/openmips_lite.sv
testbench/openmips_props.sv
testbench/tb_openmips_lite.sv

//--- Makefile
OBJ_DIR = obj_dir
LOG     = sim.log

.PHONY: help test clean

help:
	@echo "make test   build with Verilator, run the testbench, check $(LOG)"
	@echo "make clean  remove $(OBJ_DIR) and $(LOG)"
	@echo "make help   show this list"

test:
	verilator --binary --timing --assert -Wno-fatal --top-module tb_openmips_lite \
		--Mdir $(OBJ_DIR) -f build.f
	./$(OBJ_DIR)/Vtb_openmips_lite > $(LOG) 2>&1 || true
	@cat $(LOG)
	@if grep -q "Simulation finished: FAIL" $(LOG); then echo "test failed"; exit 1; fi
	@grep -q "Simulation finished: PASS" $(LOG) || (echo "run did not complete"; exit 1)

clean:
	rm -rf $(OBJ_DIR) $(LOG)

//--- testbench/tb_openmips_lite.sv
`timescale 1ns/1ns
`default_nettype none

module tb_openmips_lite import mips_pkg::*; ();

	logic        clk;
	logic        rst_i;
	logic [31:0] wb_dat_i = '0;
	logic        wb_ack_i = 1'b0;
	logic [31:0] wb_adr_o;
	logic [31:0] wb_dat_o;
	logic        wb_we_o;
	logic [3:0]  wb_sel_o;
	logic        wb_stb_o;
	logic        wb_cyc_o;

	logic [31:0] mem [1024];
	logic [31:0] prog [$];
	logic [31:0] st_addr_q [$];
	logic [31:0] st_data_q [$];
	logic [31:0] exp_addr_q [$];
	logic [31:0] exp_data_q [$];
	mem_rsp_t    load_q [$];
	integer      seed = 32'h403c_6fb0;
	bit          slow_ack = 1'b0;
	bit          in_cycle = 1'b0;
	int          delay = 0;
	bit          first_seen = 1'b0;
	logic [31:0] first_adr;
	logic [3:0]  first_sel;
	req_kind_e   first_kind;
	int          errors = 0;
	int          err_at_start = 0;
	int          tests_run = 0;
	int          tests_failed = 0;

	openmips_lite openmips_lite_inst (
		.clk      (clk),
		.rst_i    (rst_i),
		.wb_dat_i (wb_dat_i),
		.wb_ack_i (wb_ack_i),
		.wb_adr_o (wb_adr_o),
		.wb_dat_o (wb_dat_o),
		.wb_we_o  (wb_we_o),
		.wb_sel_o (wb_sel_o),
		.wb_stb_o (wb_stb_o),
		.wb_cyc_o (wb_cyc_o)
	);

	initial begin
		clk = 1'b0;
		forever #50 clk = ~clk;
	end

	// memory slave with a registered ack after 0 to 3 wait cycles
	always @(posedge clk) begin
		if (rst_i || wb_ack_i) begin
			wb_ack_i <= 1'b0;
			in_cycle = 1'b0;
		end else if (wb_cyc_o && wb_stb_o) begin
			if (!in_cycle) begin
				in_cycle = 1'b1;
				delay = slow_ack ? 3 : ($random(seed) & 3);
				if (!first_seen) begin
					first_seen = 1'b1;
					first_adr = wb_adr_o;
					first_sel = wb_sel_o;
					first_kind = wb_we_o ? REQ_STORE : REQ_FETCH;
				end
			end
			if (delay == 0) begin
				wb_ack_i <= 1'b1;
				if (wb_we_o) begin
					mem[wb_adr_o[11:2]] = wb_dat_o;
					st_addr_q.push_back(wb_adr_o);
					st_data_q.push_back(wb_dat_o);
				end else begin
					wb_dat_i <= mem[wb_adr_o[11:2]];
				end
			end else begin
				delay--;
			end
		end
	end

	// read data taken by the core while it waits for a load
	always @(posedge clk) begin
		if (!rst_i && openmips_lite_inst.rsp_valid &&
		    openmips_lite_inst.mips_core0.state == ST_WAIT_LOAD)
			load_q.push_back(openmips_lite_inst.rsp);
	end

	function automatic logic [31:0] i_type(opcode_e op, int rs, int rt, int imm);
		return {op, 5'(rs), 5'(rt), 16'(imm)};
	endfunction

	function automatic logic [31:0] r_type(funct_e fn, int rs, int rt, int rd);
		return {OP_SPECIAL, 5'(rs), 5'(rt), 5'(rd), 5'd0, fn};
	endfunction

	function automatic logic [31:0] sign_extend(int v);
		logic [15:0] h;
		h = 16'(v);
		return {{16{h[15]}}, h};
	endfunction

	function automatic logic [31:0] fill_word(int addr);
		return 32'hc0de_0000 ^ 32'(addr);
	endfunction

	task automatic compare_word(input string name, input logic [31:0] exp, input logic [31:0] act);
		if (act !== exp) begin
			$display("Fail at %0t: %s expected %h, got %h", $time, name, exp, act);
			errors++;
		end
	endtask

	task automatic check_req_kind(input string name, input req_kind_e exp, input req_kind_e act);
		if (act !== exp) begin
			$display("Fail at %0t: %s expected %s, got %s", $time, name, exp.name(), act.name());
			errors++;
		end
	endtask

	task automatic check_rsp(input string name, input mem_rsp_t exp, input mem_rsp_t act);
		if (act !== exp) begin
			$display("Fail at %0t: %s expected %h, got %h", $time, name, exp.data, act.data);
			errors++;
		end
	endtask

	task automatic check_store(input int idx, input logic [31:0] addr, input logic [31:0] data);
		if (idx >= st_addr_q.size()) begin
			$display("store %0d never reached the bus", idx);
			errors++;
		end else begin
			compare_word($sformatf("store %0d wb_adr_o", idx), addr, st_addr_q[idx]);
			compare_word($sformatf("store %0d wb_dat_o", idx), data, st_data_q[idx]);
		end
	endtask

	task automatic expect_store(input logic [31:0] addr, input logic [31:0] data);
		exp_addr_q.push_back(addr);
		exp_data_q.push_back(data);
	endtask

	task automatic start_test();
		err_at_start = errors;
		prog.delete();
		exp_addr_q.delete();
		exp_data_q.delete();
	endtask

	task automatic report_test(input string name);
		tests_run++;
		if (errors > err_at_start) begin
			tests_failed++;
			$display("test %s: %0d errors", name, errors - err_at_start);
		end else begin
			$display("test %s: ok", name);
		end
	endtask

	// load under reset, release, wait for the stores and compare them
	task automatic run_program(input bit slow);
		int cycles;
		@(posedge clk);
		rst_i <= 1'b1;
		@(posedge clk);
		// the slave ignores the bus while it sees reset
		for (int i = 0; i < 1024; i++)
			mem[i] = fill_word(i * 4);
		for (int i = 0; i < prog.size(); i++)
			mem[i] = prog[i];
		st_addr_q.delete();
		st_data_q.delete();
		load_q.delete();
		first_seen = 1'b0;
		slow_ack = slow;
		@(negedge clk);
		if (wb_cyc_o || wb_stb_o) begin
			$display("wishbone cycle active during reset at %0t", $time);
			errors++;
		end
		@(posedge clk);
		rst_i <= 1'b0;
		cycles = 0;
		while (st_addr_q.size() < exp_addr_q.size() && cycles < 3000) begin
			@(negedge clk);
			cycles++;
		end
		if (st_addr_q.size() < exp_addr_q.size()) begin
			$display("Timeout at %0t: only %0d of %0d stores reached the bus",
			         $time, st_addr_q.size(), exp_addr_q.size());
			errors++;
		end
		repeat (40) @(negedge clk);
		if (st_addr_q.size() > exp_addr_q.size()) begin
			$display("%0d stores seen where %0d were expected", st_addr_q.size(), exp_addr_q.size());
			errors++;
		end
		for (int k = 0; k < exp_addr_q.size(); k++)
			check_store(k, exp_addr_q[k], exp_data_q[k]);
	endtask

	task automatic first_fetch_after_reset();
		int cycles;
		start_test();
		prog.push_back(i_type(OP_BEQ, 0, 0, -1));
		run_program(1'b0);
		cycles = 0;
		while (!first_seen && cycles < 100) begin
			@(negedge clk);
			cycles++;
		end
		if (!first_seen) begin
			$display("Timeout at %0t: no bus cycle after reset", $time);
			errors++;
		end else begin
			check_req_kind("first wb_we_o", REQ_FETCH, first_kind);
			compare_word("first wb_adr_o", RESET_PC, first_adr);
			compare_word("first wb_sel_o", 32'(WORD_SEL), 32'(first_sel));
		end
		report_test("reset and first fetch");
	endtask

	task automatic arith_ops();
		logic [31:0] a;
		logic [31:0] b;
		start_test();
		a = sign_extend('h7fff);
		b = sign_extend(-3);
		prog.push_back(i_type(OP_ADDIU, 0, 1, 'h7fff));
		prog.push_back(i_type(OP_ADDIU, 0, 2, -3));
		prog.push_back(r_type(FN_ADDU, 1, 2, 3));
		prog.push_back(r_type(FN_SUBU, 2, 1, 4));
		prog.push_back(r_type(FN_SUBU, 1, 2, 5));
		prog.push_back(i_type(OP_ADDIU, 5, 6, -32768));
		for (int k = 0; k < 4; k++)
			prog.push_back(i_type(OP_SW, 0, k + 3, 'h200 + 4 * k));
		prog.push_back(i_type(OP_BEQ, 0, 0, -1));
		expect_store('h200, a + b);
		expect_store('h204, b - a);
		expect_store('h208, a - b);
		expect_store('h20c, a - b + sign_extend(-32768));
		run_program(1'b0);
		report_test("addiu, addu and subu");
	endtask

	task automatic load_then_store();
		logic [31:0] v;
		start_test();
		v = fill_word('h100) + sign_extend(-'h200);
		prog.push_back(i_type(OP_LW, 0, 1, 'h100));
		prog.push_back(i_type(OP_ADDIU, 1, 2, -'h200));
		prog.push_back(i_type(OP_SW, 0, 2, 'h104));
		prog.push_back(i_type(OP_LW, 0, 3, 'h104));
		prog.push_back(i_type(OP_SW, 0, 3, 'h108));
		prog.push_back(i_type(OP_BEQ, 0, 0, -1));
		expect_store('h104, v);
		expect_store('h108, v);
		run_program(1'b0);
		if (load_q.size() != 2) begin
			$display("expected 2 load responses, saw %0d", load_q.size());
			errors++;
		end else begin
			check_rsp("first load rsp", mem_rsp_t'(fill_word('h100)), load_q[0]);
			check_rsp("second load rsp", mem_rsp_t'(v), load_q[1]);
		end
		report_test("load and store ordering");
	endtask

	task automatic branch_paths();
		start_test();
		prog.push_back(i_type(OP_ADDIU, 0, 1, 7));
		prog.push_back(i_type(OP_ADDIU, 0, 2, 7));
		prog.push_back(i_type(OP_ADDIU, 0, 3, 'ha1));
		prog.push_back(i_type(OP_ADDIU, 0, 4, 'hb2));
		prog.push_back(i_type(OP_BEQ, 1, 2, 1));
		prog.push_back(i_type(OP_SW, 0, 3, 'h300));
		prog.push_back(i_type(OP_SW, 0, 4, 'h304));
		prog.push_back(i_type(OP_BNE, 1, 2, 1));
		prog.push_back(i_type(OP_SW, 0, 3, 'h308));
		prog.push_back(i_type(OP_SW, 0, 4, 'h30c));
		prog.push_back(i_type(OP_BEQ, 0, 0, -1));
		// r1 equals r2, so beq skips one word and bne falls through
		expect_store('h304, 'hb2);
		expect_store('h308, 'ha1);
		expect_store('h30c, 'hb2);
		run_program(1'b0);
		report_test("beq taken, bne not taken");
	endtask

	task automatic posted_store_burst();
		start_test();
		for (int k = 0; k < 8; k++)
			prog.push_back(i_type(OP_ADDIU, 0, k + 1, 'h50 + k));
		for (int k = 0; k < 8; k++) begin
			prog.push_back(i_type(OP_SW, 0, k + 1, 'h400 + 4 * k));
			expect_store('h400 + 4 * k, 'h50 + k);
		end
		prog.push_back(i_type(OP_BEQ, 0, 0, -1));
		run_program(1'b1);
		report_test("posted stores with slow ack");
	endtask

	task automatic zero_register();
		start_test();
		prog.push_back(i_type(OP_ADDIU, 0, 0, 'h123));
		prog.push_back(i_type(OP_SW, 0, 0, 'h500));
		prog.push_back(i_type(OP_BEQ, 0, 0, -1));
		expect_store('h500, 32'd0);
		run_program(1'b0);
		report_test("register zero");
	endtask

	initial begin
		rst_i = 1'b1;
		first_fetch_after_reset();
		arith_ops();
		load_then_store();
		branch_paths();
		posted_store_burst();
		zero_register();
		$display("%0d tests run, %0d failed, %0d errors", tests_run, tests_failed, errors);
		if (errors == 0)
			$display("Simulation finished: PASS");
		else
			$display("Simulation finished: FAIL");
		$finish;
	end

endmodule

`default_nettype wire

//--- testbench/openmips_props.sv
`timescale 1ns/1ns
`default_nettype none

module openmips_props (
	input wire        clk,
	input wire        rst_i,
	input wire        wb_cyc_o,
	input wire        wb_stb_o,
	input wire        wb_ack_i,
	input wire        wb_we_o,
	input wire [31:0] wb_adr_o,
	input wire [31:0] wb_dat_o
);

	// the master closes the cycle in the cycle after the ack
	ack_ends_cycle: assert property (@(posedge clk) disable iff (rst_i)
		wb_cyc_o && wb_ack_i |=> !wb_cyc_o && !wb_stb_o)
		else $error("wishbone cycle still open after ack");

	// request held steady until the slave acks
	req_stable_until_ack: assert property (@(posedge clk) disable iff (rst_i)
		wb_stb_o && !wb_ack_i |=> wb_stb_o && $stable(wb_adr_o) &&
		                         $stable(wb_dat_o) && $stable(wb_we_o))
		else $error("wishbone request changed before ack");

	cyc_low_after_reset: assert property (@(posedge clk)
		rst_i |=> !wb_cyc_o)
		else $error("wishbone cyc high in the cycle after reset");

endmodule

bind wishbone_bus openmips_props props0 (
	.clk      (clk),
	.rst_i    (rst_i),
	.wb_cyc_o (wb_cyc_o),
	.wb_stb_o (wb_stb_o),
	.wb_ack_i (wb_ack_i),
	.wb_we_o  (wb_we_o),
	.wb_adr_o (wb_adr_o),
	.wb_dat_o (wb_dat_o)
);

`default_nettype wire

//--- verilog/openmips_lite.sv
`timescale 1ns/1ns
`default_nettype none

module openmips_lite import mips_pkg::*; (
	input  wire         clk,
	input  wire         rst_i,
	input  wire  [31:0] wb_dat_i,
	input  wire         wb_ack_i,
	output logic [31:0] wb_adr_o,
	output logic [31:0] wb_dat_o,
	output logic        wb_we_o,
	output logic [3:0]  wb_sel_o,
	output logic        wb_stb_o,
	output logic        wb_cyc_o
);

	// core to queue
	logic     core_req_valid;
	mem_req_t core_req;
	logic     core_req_ready;

	// queue to bus master
	logic     pop_valid;
	mem_req_t pop_req;
	logic     pop_ready;

	// read data back to the core
	logic     rsp_valid;
	mem_rsp_t rsp;

	mips_core mips_core0 (
		.clk         (clk),
		.rst_i       (rst_i),
		.req_valid_o (core_req_valid),
		.req_o       (core_req),
		.req_ready_i (core_req_ready),
		.rsp_valid_i (rsp_valid),
		.rsp_i       (rsp)
	);

	mem_req_fifo mem_req_fifo0 (
		.clk          (clk),
		.rst_i        (rst_i),
		.push_valid_i (core_req_valid),
		.push_i       (core_req),
		.push_ready_o (core_req_ready),
		.pop_valid_o  (pop_valid),
		.pop_o        (pop_req),
		.pop_ready_i  (pop_ready)
	);

	wishbone_bus wishbone_bus0 (
		.clk         (clk),
		.rst_i       (rst_i),
		.pop_valid_i (pop_valid),
		.pop_i       (pop_req),
		.pop_ready_o (pop_ready),
		.rsp_valid_o (rsp_valid),
		.rsp_o       (rsp),
		.wb_dat_i    (wb_dat_i),
		.wb_ack_i    (wb_ack_i),
		.wb_adr_o    (wb_adr_o),
		.wb_dat_o    (wb_dat_o),
		.wb_we_o     (wb_we_o),
		.wb_sel_o    (wb_sel_o),
		.wb_stb_o    (wb_stb_o),
		.wb_cyc_o    (wb_cyc_o)
	);

endmodule

`default_nettype wire

//--- verilog/wishbone_bus.sv
`timescale 1ns/1ns
`default_nettype none

module wishbone_bus import mips_pkg::*; (
	input  wire           clk,
	input  wire           rst_i,
	input  wire           pop_valid_i,
	input  wire mem_req_t pop_i,
	output logic          pop_ready_o,
	output logic          rsp_valid_o,
	output mem_rsp_t      rsp_o,
	input  wire  [31:0]   wb_dat_i,
	input  wire           wb_ack_i,
	output logic [31:0]   wb_adr_o,
	output logic [31:0]   wb_dat_o,
	output logic          wb_we_o,
	output logic [3:0]    wb_sel_o,
	output logic          wb_stb_o,
	output logic          wb_cyc_o
);

	typedef enum logic {
		BUS_IDLE,
		BUS_BUSY
	} bus_state_e;

	bus_state_e state;
	mem_req_t   cur_req;
	logic       pop_fire;

	assign pop_ready_o = (state == BUS_IDLE);
	assign pop_fire    = pop_valid_i && pop_ready_o;

	// one classic cycle per request held until ack
	assign wb_cyc_o = (state == BUS_BUSY);
	assign wb_stb_o = (state == BUS_BUSY);
	assign wb_adr_o = cur_req.addr;
	assign wb_dat_o = cur_req.wdata;
	assign wb_we_o  = (cur_req.kind == REQ_STORE);
	assign wb_sel_o = WORD_SEL;

	always_ff @(posedge clk) begin
		if (rst_i) begin
			state <= BUS_IDLE;
		end else begin
			case (state)
				BUS_IDLE: begin
					if (pop_fire)
						state <= BUS_BUSY;
				end
				BUS_BUSY: begin
					if (wb_ack_i)
						state <= BUS_IDLE;
				end
				default: state <= BUS_IDLE;
			endcase
		end
	end

	always_ff @(posedge clk) begin
		if (pop_fire)
			cur_req <= pop_i;
	end

	// stores are posted and only reads answer the core
	always_ff @(posedge clk) begin
		if (rst_i)
			rsp_valid_o <= 1'b0;
		else
			rsp_valid_o <= (state == BUS_BUSY) && wb_ack_i && (cur_req.kind != REQ_STORE);
	end

	always_ff @(posedge clk) begin
		if (state == BUS_BUSY && wb_ack_i)
			rsp_o.data <= wb_dat_i;
	end

endmodule

`default_nettype wire

//--- verilog/mem_req_fifo.sv
`timescale 1ns/1ns
`default_nettype none

module mem_req_fifo import mips_pkg::*; (
	input  wire           clk,
	input  wire           rst_i,
	input  wire           push_valid_i,
	input  wire mem_req_t push_i,
	output logic          push_ready_o,
	output logic          pop_valid_o,
	output mem_req_t      pop_o,
	input  wire           pop_ready_i
);

	mem_req_t             entries [REQ_DEPTH];
	logic [REQ_PTR_W-1:0] wr_ptr;
	logic [REQ_PTR_W-1:0] rd_ptr;
	logic [REQ_PTR_W:0]   count;
	logic                 push_fire;
	logic                 pop_fire;

	assign push_ready_o = (count != (REQ_PTR_W+1)'(REQ_DEPTH));
	assign pop_valid_o  = (count != '0);
	assign pop_o        = entries[rd_ptr];

	assign push_fire = push_valid_i && push_ready_o;
	assign pop_fire  = pop_valid_o && pop_ready_i;

	always_ff @(posedge clk) begin
		if (push_fire)
			entries[wr_ptr] <= push_i;
	end

	// pointers wrap on overflow as the depth is a power of two
	always_ff @(posedge clk) begin
		if (rst_i) begin
			wr_ptr <= '0;
			rd_ptr <= '0;
			count  <= '0;
		end else begin
			if (push_fire)
				wr_ptr <= wr_ptr + 1'b1;
			if (pop_fire)
				rd_ptr <= rd_ptr + 1'b1;
			case ({push_fire, pop_fire})
				2'b10:   count <= count + 1'b1;
				2'b01:   count <= count - 1'b1;
				default: count <= count;
			endcase
		end
	end

endmodule

`default_nettype wire

//--- core/mips_core.sv
`timescale 1ns/1ns
`default_nettype none

module mips_core import mips_pkg::*; (
	input  wire           clk,
	input  wire           rst_i,
	output logic          req_valid_o,
	output mem_req_t      req_o,
	input  wire           req_ready_i,
	input  wire           rsp_valid_i,
	input  wire mem_rsp_t rsp_i
);

	core_state_e state;
	logic [31:0] pc;
	logic [31:0] ir;

	opcode_e     op;
	funct_e      fn;
	logic [4:0]  rs;
	logic [4:0]  rt;
	logic [4:0]  rd;
	logic [31:0] imm_sext;
	logic [31:0] pc_plus4;
	logic [31:0] branch_target;
	logic [31:0] mem_addr;
	logic [31:0] rs_val;
	logic [31:0] rt_val;
	logic [31:0] alu_result;
	logic [4:0]  alu_dest;
	logic        is_alu;
	logic        is_lw;
	logic        is_sw;
	logic        branch_taken;
	logic        req_fire;
	logic        rf_we;
	logic [4:0]  rf_waddr;
	logic [31:0] rf_wdata;

	// instruction fields
	assign op       = opcode_e'(ir[31:26]);
	assign fn       = funct_e'(ir[5:0]);
	assign rs       = ir[25:21];
	assign rt       = ir[20:16];
	assign rd       = ir[15:11];
	assign imm_sext = {{16{ir[15]}}, ir[15:0]};

	assign pc_plus4      = pc + 32'd4;
	// offset is in words
	assign branch_target = pc_plus4 + {imm_sext[29:0], 2'b00};
	assign mem_addr      = rs_val + imm_sext;

	assign is_lw        = (op == OP_LW);
	assign is_sw        = (op == OP_SW);
	assign branch_taken = (op == OP_BEQ && rs_val == rt_val) ||
	                      (op == OP_BNE && rs_val != rt_val);

	regfile regfile0 (
		.clk      (clk),
		.rst_i    (rst_i),
		.we_i     (rf_we),
		.waddr_i  (rf_waddr),
		.wdata_i  (rf_wdata),
		.raddr1_i (rs),
		.rdata1_o (rs_val),
		.raddr2_i (rt),
		.rdata2_o (rt_val)
	);

	always_comb begin
		is_alu     = 1'b0;
		alu_result = '0;
		alu_dest   = rd;
		case (op)
			OP_SPECIAL: begin
				if (fn == FN_ADDU) begin
					is_alu     = 1'b1;
					alu_result = rs_val + rt_val;
				end else if (fn == FN_SUBU) begin
					is_alu     = 1'b1;
					alu_result = rs_val - rt_val;
				end
			end
			OP_ADDIU: begin
				is_alu     = 1'b1;
				alu_result = rs_val + imm_sext;
				alu_dest   = rt;
			end
			default: ;
		endcase
	end

	// memory request towards the queue
	always_comb begin
		req_valid_o = 1'b0;
		req_o.kind  = REQ_FETCH;
		req_o.addr  = pc;
		req_o.wdata = '0;
		case (state)
			ST_FETCH: req_valid_o = 1'b1;
			ST_EXEC: begin
				if (is_lw) begin
					req_valid_o = 1'b1;
					req_o.kind  = REQ_LOAD;
					req_o.addr  = mem_addr;
				end else if (is_sw) begin
					req_valid_o = 1'b1;
					req_o.kind  = REQ_STORE;
					req_o.addr  = mem_addr;
					req_o.wdata = rt_val;
				end
			end
			default: ;
		endcase
	end

	assign req_fire = req_valid_o && req_ready_i;

	// alu result in EXEC, load data in WAIT_LOAD
	assign rf_we    = (state == ST_EXEC && is_alu) || (state == ST_WAIT_LOAD && rsp_valid_i);
	assign rf_waddr = (state == ST_WAIT_LOAD) ? rt : alu_dest;
	assign rf_wdata = (state == ST_WAIT_LOAD) ? rsp_i.data : alu_result;

	always_ff @(posedge clk) begin
		if (rst_i) begin
			state <= ST_FETCH;
			pc    <= RESET_PC;
		end else begin
			case (state)
				ST_FETCH: begin
					if (req_fire)
						state <= ST_WAIT_INST;
				end
				ST_WAIT_INST: begin
					if (rsp_valid_i)
						state <= ST_EXEC;
				end
				ST_EXEC: begin
					if (is_lw || is_sw) begin
						// stay here until the queue has room
						if (req_fire) begin
							pc <= pc_plus4;
							if (is_lw)
								state <= ST_WAIT_LOAD;
							else
								state <= ST_FETCH;
						end
					end else begin
						pc    <= branch_taken ? branch_target : pc_plus4;
						state <= ST_FETCH;
					end
				end
				ST_WAIT_LOAD: begin
					if (rsp_valid_i)
						state <= ST_FETCH;
				end
				default: state <= ST_FETCH;
			endcase
		end
	end

	always_ff @(posedge clk) begin
		if (state == ST_WAIT_INST && rsp_valid_i)
			ir <= rsp_i.data;
	end

endmodule

`default_nettype wire

//--- core/regfile.sv
`timescale 1ns/1ns
`default_nettype none

module regfile (
	input  wire         clk,
	input  wire         rst_i,
	input  wire         we_i,
	input  wire  [4:0]  waddr_i,
	input  wire  [31:0] wdata_i,
	input  wire  [4:0]  raddr1_i,
	output logic [31:0] rdata1_o,
	input  wire  [4:0]  raddr2_i,
	output logic [31:0] rdata2_o
);

	logic [31:0] regs [32];

	always_ff @(posedge clk) begin
		if (rst_i) begin
			for (int i = 0; i < 32; i++) begin
				regs[i] <= '0;
			end
		end else if (we_i && waddr_i != 5'd0) begin
			regs[waddr_i] <= wdata_i;
		end
	end

	// $zero reads as zero whatever the array holds
	assign rdata1_o = (raddr1_i == 5'd0) ? 32'd0 : regs[raddr1_i];
	assign rdata2_o = (raddr2_i == 5'd0) ? 32'd0 : regs[raddr2_i];

endmodule

`default_nettype wire

//--- common/mips_pkg.sv
`default_nettype none

package mips_pkg;

	// major opcodes handled by the core
	typedef enum logic [5:0] {
		OP_SPECIAL = 6'h00,
		OP_BEQ     = 6'h04,
		OP_BNE     = 6'h05,
		OP_ADDIU   = 6'h09,
		OP_LW      = 6'h23,
		OP_SW      = 6'h2b
	} opcode_e;

	// function field of the SPECIAL group
	typedef enum logic [5:0] {
		FN_ADDU = 6'h21,
		FN_SUBU = 6'h23
	} funct_e;

	typedef enum logic [1:0] {
		ST_FETCH,
		ST_WAIT_INST,
		ST_EXEC,
		ST_WAIT_LOAD
	} core_state_e;

	typedef enum logic [1:0] {
		REQ_FETCH,
		REQ_LOAD,
		REQ_STORE
	} req_kind_e;

	typedef struct packed {
		req_kind_e   kind;
		logic [31:0] addr;
		logic [31:0] wdata;
	} mem_req_t;

	typedef struct packed {
		logic [31:0] data;
	} mem_rsp_t;

	localparam int          REQ_DEPTH = 4;
	localparam int          REQ_PTR_W = $clog2(REQ_DEPTH);
	localparam logic [31:0] RESET_PC  = 32'h0000_0000;
	localparam logic [3:0]  WORD_SEL  = 4'b1111;

endpackage

`default_nettype wire
